// File: hw/skew_pkg.sv
// Sizes are fixed here for every bank; 2**ADDR_WIDTH must be at least NUM_ROW or the skew wraps
package skew_pkg;

    // ==================================================
    // Array geometry
    // ==================================================

    // Bits per activation
    localparam int ACT_WIDTH  = 8;

    // Independent banks, each with its own handshakes
    localparam int NUM_BANK   = 2;

    // Rows per bank, also the skew depth
    // Row j lags row 0 by j vectors
    localparam int NUM_ROW    = 4;

    // ==================================================
    // Storage sizing
    // ==================================================

    // RAM address bits per row
    // 2**ADDR_WIDTH must be >= NUM_ROW
    localparam int ADDR_WIDTH = 3;

    // Entries per row RAM
    localparam int RAM_DEPTH  = 2 ** ADDR_WIDTH;

    // Occupancy count, one extra bit so full is representable
    localparam int CNT_WIDTH  = ADDR_WIDTH + 1;

    // Flat widths used on the top-level buses
    // One bank's vector
    localparam int VEC_WIDTH  = NUM_ROW * ACT_WIDTH;

    // All banks together
    localparam int BUS_WIDTH  = NUM_BANK * VEC_WIDTH;

endpackage

// File: hw/skew_ram.sv
// One row of one bank; no read-during-write bypass, caller must not read an address written the same cycle
`timescale 1ns/100ps

module skew_ram
    import skew_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clear_i,

    // Write port, one activation per push
    input  logic                  wr_en_i,
    input  logic [ADDR_WIDTH-1:0] wr_addr_i,
    input  logic [ACT_WIDTH-1:0]  wr_data_i,

    // Read request from the bank pop logic
    input  logic                  rd_req_i,
    input  logic [ADDR_WIDTH-1:0] rd_addr_i,

    // Held read result with valid/ready
    output logic                  rd_vld_o,
    input  logic                  rd_rdy_i,
    output logic [ACT_WIDTH-1:0]  rd_data_o
);

    // ==================================================
    // Storage
    // ==================================================

    // Row storage, one entry per pointer value
    logic [ACT_WIDTH-1:0] mem [RAM_DEPTH];

    // Output holding register
    logic [ACT_WIDTH-1:0] rd_data_q;

    // Holding register occupied
    logic                 rd_vld_q;

    // Synchronous write
    // Contents survive clear, pointers in the bank make them stale
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // ==================================================
    // Registered read
    // ==================================================

    // Load on request only
    // Old value stays put while the consumer stalls
    always_ff @(posedge clk) begin
        if (rd_req_i) begin
            rd_data_q <= mem[rd_addr_i];
        end
    end

    // Valid flag of the holding register
    // New request wins over a same-cycle handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld_q <= 1'b0;
        end else if (clear_i) begin
            rd_vld_q <= 1'b0;
        end else if (rd_req_i) begin
            rd_vld_q <= 1'b1;
        end else if (rd_rdy_i) begin
            // Consumed with nothing behind it
            rd_vld_q <= 1'b0;
        end
    end

    // Outputs straight from the registers
    assign rd_vld_o  = rd_vld_q;
    assign rd_data_o = rd_data_q;

    // ==================================================
    // Checks
    // ==================================================

    // Stalled output must not change until taken
    // Relies on the bank never requesting into a full, stalled register
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_vld_o && !rd_rdy_i && !clear_i |=> $stable(rd_data_o)
    ) else $error("skew_ram: rd_data_o changed while stalled");

endmodule

// File: hw/skew_bank.sv
// One bank; pops only with NUM_ROW vectors held, so the first NUM_ROW-1 vectors never come out alone
`timescale 1ns/100ps

module skew_bank
    import skew_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               clear_i,

    // Input vector, row j in slice j
    input  logic [NUM_ROW-1:0][ACT_WIDTH-1:0]  din_data_i,
    input  logic                               din_vld_i,
    output logic                               din_rdy_o,

    // Skewed output vector
    output logic [NUM_ROW-1:0][ACT_WIDTH-1:0]  out_data_o,
    output logic                               out_vld_o,
    input  logic                               out_rdy_i
);

    // ==================================================
    // Pointer and count control
    // ==================================================

    // Next write slot, counts pushes
    logic [ADDR_WIDTH-1:0] wr_ptr;

    // Next read slot, counts pops
    logic [ADDR_WIDTH-1:0] rd_ptr;

    // Vectors pushed and not yet popped
    logic [CNT_WIDTH-1:0]  cnt;

    logic                  full;
    logic                  pop_ok;
    logic                  push;
    logic                  pop;

    // Per-row read valid, all rows move in lockstep
    logic [NUM_ROW-1:0]    row_vld;

    // Diagonal write address per row
    logic [NUM_ROW-1:0][ADDR_WIDTH-1:0] row_wr_addr;

    // Count limits
    assign full   = (cnt == CNT_WIDTH'(RAM_DEPTH));
    assign pop_ok = (cnt >= CNT_WIDTH'(NUM_ROW));

    // Ready from count only, never from din_vld_i
    assign din_rdy_o = !full;

    // Input handshake is the common write strobe
    assign push = din_vld_i && din_rdy_o;

    // Pop when a full diagonal is held and the output slot frees up
    // Held during clear so the stalled word stays put
    assign pop = pop_ok && (!out_vld_o || out_rdy_i) && !clear_i;

    // Write pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Read pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (clear_i) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Occupancy count
    // Push and pop together leave it unchanged
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (clear_i) begin
            cnt <= '0;
        end else if (push && !pop) begin
            cnt <= cnt + 1'b1;
        end else if (pop && !push) begin
            cnt <= cnt - 1'b1;
        end
    end

    // ==================================================
    // Row RAMs
    // ==================================================

    // Row j stores vector v at address v-j
    // A read at rd_ptr then gives element j of vector rd_ptr+j
    for (genvar j = 0; j < NUM_ROW; j++) begin : g_row

        logic [ACT_WIDTH-1:0] row_data;

        // Wraps modulo RAM_DEPTH by width
        assign row_wr_addr[j] = wr_ptr - ADDR_WIDTH'(j);

        skew_ram ram_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .clear_i   (clear_i),
            .wr_en_i   (push),
            .wr_addr_i (row_wr_addr[j]),
            .wr_data_i (din_data_i[j]),
            .rd_req_i  (pop),
            .rd_addr_i (rd_ptr),
            .rd_vld_o  (row_vld[j]),
            .rd_rdy_i  (out_rdy_i),
            .rd_data_o (row_data)
        );

        assign out_data_o[j] = row_data;
    end

    // Bank valid only when every row holds data
    assign out_vld_o = &row_vld;

    // ==================================================
    // Checks
    // ==================================================

    // Count bounded by storage
    a_cnt_max: assert property (
        @(posedge clk) disable iff (!rst_n)
        cnt <= CNT_WIDTH'(RAM_DEPTH)
    ) else $error("skew_bank: count above RAM_DEPTH");

    // Rows share requests, so their valids must agree
    a_rows_lockstep: assert property (
        @(posedge clk) disable iff (!rst_n)
        row_vld == {NUM_ROW{row_vld[0]}}
    ) else $error("skew_bank: row valids diverged");

    // Full blocks writes, the write pointer must not advance
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        full && !clear_i |=> wr_ptr == $past(wr_ptr)
    ) else $error("skew_bank: write accepted while full");

endmodule

// File: hw/act_skew_top.sv
// Banks share clock, reset and clear only; each bank's handshakes run on their own
`timescale 1ns/100ps

module act_skew_top
    import skew_pkg::*;
(
    input  logic                                             clk,
    input  logic                                             rst_n,

    // Synchronous clear of every bank
    input  logic                                             clear_i,

    // Input vectors, bank b in slice b
    input  logic [NUM_BANK-1:0][NUM_ROW-1:0][ACT_WIDTH-1:0]  din_data_i,
    input  logic [NUM_BANK-1:0]                              din_vld_i,
    output logic [NUM_BANK-1:0]                              din_rdy_o,

    // Skewed output vectors toward the array
    output logic [NUM_BANK-1:0][NUM_ROW-1:0][ACT_WIDTH-1:0]  out_data_o,
    output logic [NUM_BANK-1:0]                              out_vld_o,
    input  logic [NUM_BANK-1:0]                              out_rdy_i
);

    // ==================================================
    // Bank array
    // ==================================================

    // Flat views of the vector buses
    // Instance array splits these into VEC_WIDTH slices
    logic [BUS_WIDTH-1:0] din_flat;
    logic [BUS_WIDTH-1:0] out_flat;

    assign din_flat   = din_data_i;
    assign out_data_o = out_flat;

    // One bank per slice
    // Shared clock, reset and clear
    skew_bank bank_i [NUM_BANK-1:0] (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear_i    (clear_i),
        .din_data_i (din_flat),
        .din_vld_i  (din_vld_i),
        .din_rdy_o  (din_rdy_o),
        .out_data_o (out_flat),
        .out_vld_o  (out_vld_o),
        .out_rdy_i  (out_rdy_i)
    );

endmodule

// File: tests/act_skew_tb.sv
// Stimulus file format is fixed to NUM_BANK=2 and 32-bit bank vectors; run from the project root
`timescale 1ns/100ps

module act_skew_tb
    import skew_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int MAX_REC    = 256;

    logic                                            clk;
    logic                                            rst_n;
    logic                                            clear_i;
    logic [NUM_BANK-1:0][NUM_ROW-1:0][ACT_WIDTH-1:0] din_data_i;
    logic [NUM_BANK-1:0]                             din_vld_i;
    logic [NUM_BANK-1:0]                             din_rdy_o;
    logic [NUM_BANK-1:0][NUM_ROW-1:0][ACT_WIDTH-1:0] out_data_o;
    logic [NUM_BANK-1:0]                             out_vld_o;
    logic [NUM_BANK-1:0]                             out_rdy_i;

    // ==================================================
    // Stimulus storage
    // ==================================================

    // One input record per cycle
    logic                 rec_clr  [MAX_REC];
    logic [NUM_BANK-1:0]  rec_vld  [MAX_REC];
    byte                  rec_mode [MAX_REC][NUM_BANK];
    logic [VEC_WIDTH-1:0] rec_data [MAX_REC][NUM_BANK];
    int                   n_rec;
    int                   drain_cycles;

    // Expected output vectors per bank
    logic [VEC_WIDTH-1:0] exp_q [NUM_BANK][$];

    // Scoreboard state since reset or clear
    int                   pushes [NUM_BANK];
    int                   outs   [NUM_BANK];
    logic                 held   [NUM_BANK];
    logic [VEC_WIDTH-1:0] held_data [NUM_BANK];
    logic                 clr_seen;
    int                   in_handshakes;
    int                   errors;
    logic                 loaded;

    act_skew_top act_skew_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear_i    (clear_i),
        .din_data_i (din_data_i),
        .din_vld_i  (din_vld_i),
        .din_rdy_o  (din_rdy_o),
        .out_data_o (out_data_o),
        .out_vld_o  (out_vld_o),
        .out_rdy_i  (out_rdy_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // File reading
    // ==================================================

    task automatic load_stimulus();
        int          fd;
        int          code;
        int          clr;
        int          bank;
        int          m0;
        int          m1;
        byte         kind;
        string       line;
        logic [31:0] vm;
        logic [31:0] d0;
        logic [31:0] d1;
        fd = $fopen("tests/skew_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: stimulus file could not be opened");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2) begin
                continue;
            end
            kind = line.getc(0);
            if (kind == "I") begin
                code = $sscanf(line, "I %d %h %c %c %h %h", clr, vm, m0, m1, d0, d1);
                if (code != 6 || n_rec >= MAX_REC) begin
                    $display("ERROR: bad or surplus input record: %s", line);
                    errors++;
                end else begin
                    rec_clr[n_rec]     = (clr != 0);
                    rec_vld[n_rec]     = vm[NUM_BANK-1:0];
                    rec_mode[n_rec][0] = byte'(m0);
                    rec_mode[n_rec][1] = byte'(m1);
                    rec_data[n_rec][0] = d0;
                    rec_data[n_rec][1] = d1;
                    n_rec++;
                end
            end else if (kind == "X") begin
                code = $sscanf(line, "X %d %h", bank, d0);
                exp_q[bank].push_back(d0);
            end else if (kind == "D") begin
                code = $sscanf(line, "D %d", drain_cycles);
            end
        end
        $fclose(fd);
    endtask

    // Drive one record with a fresh random ready draw
    // Valid only for banks that have not yet taken this record
    task automatic apply_record(input int idx, input logic [NUM_BANK-1:0] mask);
        clear_i   = rec_clr[idx];
        din_vld_i = rec_vld[idx] & mask;
        for (int b = 0; b < NUM_BANK; b++) begin
            din_data_i[b] = rec_data[idx][b];
            if (rec_mode[idx][b] == "R") begin
                out_rdy_i[b] = 1'($urandom() & 1);
            end else begin
                out_rdy_i[b] = (rec_mode[idx][b] == "1");
            end
        end
    endtask

    task automatic report_queues();
        for (int b = 0; b < NUM_BANK; b++) begin
            if (exp_q[b].size() != 0) begin
                $display("ERROR: bank %0d still expects %0d output vectors",
                         b, exp_q[b].size());
                errors++;
            end
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        int                  idx;
        int                  exp_handshakes;
        logic                stall;
        logic [NUM_BANK-1:0] pending;
        clear_i       = 1'b0;
        din_vld_i     = '0;
        din_data_i    = '0;
        out_rdy_i     = '0;
        rst_n         = 1'b0;
        n_rec         = 0;
        drain_cycles  = 0;
        errors        = 0;
        in_handshakes = 0;
        loaded        = 1'b0;
        void'($urandom(12284));
        load_stimulus();
        loaded = 1'b1;
        // Every valid bit in the file is one vector to be accepted once
        exp_handshakes = 0;
        for (int i = 0; i < n_rec; i++) begin
            exp_handshakes += $countones(rec_vld[i]);
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idx     = 0;
        pending = '1;
        while (idx < n_rec) begin
            apply_record(idx, pending);
            @(negedge clk);
            // Hold the record while any valid bank is not ready
            stall   = |(din_vld_i & ~din_rdy_o);
            pending = pending & ~(din_vld_i & din_rdy_o);
            @(posedge clk);
            #1;
            if (!stall) begin
                idx++;
                pending = '1;
            end
        end
        // Drain with every output ready
        clear_i   = 1'b0;
        din_vld_i = '0;
        out_rdy_i = '1;
        repeat (drain_cycles) @(posedge clk);
        report_queues();
        if (in_handshakes != exp_handshakes) begin
            $display("FAIL in_handshakes expected %h actual %h",
                     exp_handshakes, in_handshakes);
            errors++;
        end
        $display("errors: %0d, input handshakes: %0d", errors, in_handshakes);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // ==================================================
    // Monitor
    // ==================================================

    // Samples mid-cycle where all signals are stable
    always @(negedge clk) begin
        int   occ;
        logic exp_rdy;
        if (!rst_n) begin
            if (out_vld_o !== '0 || din_rdy_o !== '1) begin
                $display("FAIL reset out_vld_o %h din_rdy_o %h", out_vld_o, din_rdy_o);
                errors++;
            end
            for (int b = 0; b < NUM_BANK; b++) begin
                pushes[b] = 0;
                outs[b]   = 0;
                held[b]   = 1'b0;
            end
            clr_seen = 1'b0;
        end else begin
            for (int b = 0; b < NUM_BANK; b++) begin
                // Popped vectors include the one sitting in the output register
                occ     = pushes[b] - outs[b] - int'(out_vld_o[b]);
                exp_rdy = (occ != RAM_DEPTH);
                if (din_rdy_o[b] !== exp_rdy) begin
                    $display("FAIL din_rdy_o bank %0d expected %h actual %h",
                             b, exp_rdy, din_rdy_o[b]);
                    errors++;
                end
                if (clr_seen && out_vld_o[b] !== 1'b0) begin
                    $display("FAIL out_vld_o bank %0d expected %h actual %h after clear",
                             b, 1'b0, out_vld_o[b]);
                    errors++;
                end
                // Stalled word must not move
                if (held[b] && out_data_o[b] !== held_data[b]) begin
                    $display("FAIL out_data_o bank %0d expected %h actual %h while stalled",
                             b, held_data[b], out_data_o[b]);
                    errors++;
                end
                if (clear_i) begin
                    pushes[b] = 0;
                    outs[b]   = 0;
                    held[b]   = 1'b0;
                end else begin
                    if (out_vld_o[b] && out_rdy_i[b]) begin
                        if (outs[b] + NUM_ROW > pushes[b]) begin
                            $display("ERROR: bank %0d gave output %0d after only %0d pushes",
                                     b, outs[b], pushes[b]);
                            errors++;
                        end
                        if (exp_q[b].size() == 0) begin
                            $display("ERROR: bank %0d gave an output with none expected", b);
                            errors++;
                        end else if (out_data_o[b] !== exp_q[b][0]) begin
                            $display("FAIL out_data_o bank %0d expected %h actual %h",
                                     b, exp_q[b][0], out_data_o[b]);
                            errors++;
                            void'(exp_q[b].pop_front());
                        end else begin
                            void'(exp_q[b].pop_front());
                        end
                        outs[b]++;
                    end
                    if (din_vld_i[b] && din_rdy_o[b]) begin
                        pushes[b]++;
                        in_handshakes++;
                    end
                    held[b]      = out_vld_o[b] && !out_rdy_i[b];
                    held_data[b] = out_data_o[b];
                end
            end
            clr_seen = clear_i;
        end
    end

    // Watchdog sized from the record count
    initial begin
        int timeout_ns;
        wait (loaded);
        timeout_ns = (n_rec + drain_cycles + 100) * CLK_PERIOD;
        #(timeout_ns);
        $display("ERROR: watchdog expired after %0d ns", timeout_ns);
        report_queues();
        $display("errors: %0d, input handshakes: %0d", errors, in_handshakes);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: tests/skew_stimulus.txt
# I clear vld_mask rdy_mode_b0 rdy_mode_b1 data_b0 data_b1 (rdy mode 0/1/R, data row3..row0)
# X bank expected_vector, D drain_cycles
I 0 1 1 1 03020100 00000000
I 0 1 1 1 13121110 00000000
I 0 1 1 1 23222120 00000000
I 0 1 1 1 33323130 00000000
I 0 1 1 1 43424140 00000000
I 0 1 1 1 53525150 00000000
I 0 1 1 1 63626160 00000000
I 0 1 1 1 73727170 00000000
I 0 1 1 1 83828180 00000000
I 0 1 1 1 93929190 00000000
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 1 0 1 1 00000000 00000000
I 0 1 1 1 43424140 00000000
I 0 2 1 1 00000000 83828180
I 0 3 1 1 53525150 93929190
I 0 1 1 1 63626160 00000000
I 0 3 1 1 73727170 A3A2A1A0
I 0 2 1 1 00000000 B3B2B1B0
I 0 3 1 1 83828180 C3C2C1C0
I 0 3 1 1 93929190 D3D2D1D0
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 1 0 1 1 00000000 00000000
I 0 1 0 1 03020100 00000000
I 0 1 0 1 13121110 00000000
I 0 1 0 1 23222120 00000000
I 0 1 0 1 33323130 00000000
I 0 1 0 1 43424140 00000000
I 0 1 0 1 53525150 00000000
I 0 1 0 1 63626160 00000000
I 0 1 0 1 73727170 00000000
I 0 1 0 1 83828180 00000000
I 0 0 0 1 00000000 00000000
I 0 0 0 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 1 0 1 1 00000000 00000000
I 0 2 1 R 00000000 03020100
I 0 0 1 R 00000000 00000000
I 0 2 1 R 00000000 13121110
I 0 2 1 R 00000000 23222120
I 0 0 1 R 00000000 00000000
I 0 2 1 R 00000000 33323130
I 0 2 1 R 00000000 43424140
I 0 0 1 R 00000000 00000000
I 0 2 1 R 00000000 53525150
I 0 2 1 R 00000000 63626160
I 0 0 1 R 00000000 00000000
I 0 2 1 R 00000000 73727170
I 0 0 1 R 00000000 00000000
I 0 0 1 R 00000000 00000000
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 0 0 1 1 00000000 00000000
I 0 1 0 1 03020100 00000000
I 0 1 0 1 13121110 00000000
I 0 1 0 1 23222120 00000000
I 0 1 0 1 33323130 00000000
I 0 1 0 1 43424140 00000000
I 0 0 0 1 00000000 00000000
I 1 0 0 1 00000000 00000000
I 0 1 1 1 A3A2A1A0 00000000
I 0 1 1 1 B3B2B1B0 00000000
I 0 1 1 1 C3C2C1C0 00000000
I 0 1 1 1 D3D2D1D0 00000000
I 0 1 1 1 E3E2E1E0 00000000
X 0 33221100
X 0 43322110
X 0 53423120
X 0 63524130
X 0 73625140
X 0 83726150
X 0 93827160
X 0 73625140
X 0 83726150
X 0 93827160
X 1 B3A29180
X 1 C3B2A190
X 1 D3C2B1A0
X 0 33221100
X 0 43322110
X 0 53423120
X 0 63524130
X 0 73625140
X 0 83726150
X 1 33221100
X 1 43322110
X 1 53423120
X 1 63524130
X 1 73625140
X 0 D3C2B1A0
X 0 E3D2C1B0
D 12

// File: act_skew_top.f
hw/skew_pkg.sv
hw/skew_ram.sv
hw/skew_bank.sv
hw/act_skew_top.sv
tests/act_skew_tb.sv

// File: Makefile
TOP := act_skew_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f act_skew_top.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
